//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = agu_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@! grep -q "Test FAILED" $(LOG)
	@grep -q "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
hw/agu_pkg.sv
hw/agu_issue_buffer.sv
hw/agu_store_stage.sv
hw/agu_load_req.sv
hw/agu_load_resp.sv
hw/dcache_port.sv
hw/agu_top.sv
sim/agu_assert.sv
sim/agu_checker.sv
sim/agu_tb.sv

//--- hw/agu_issue_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module agu_issue_buffer #(
    parameter type payload_t = agu_pkg::mem_issue_t
) (
    input  logic     clk,
    input  logic     reset,

    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_allowin,

    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_allowin
);

    payload_t   entry [2];
    logic       head;
    logic       tail;
    logic [1:0] count;
    logic       push;
    logic       pop;

    // allowin depends only on occupancy and never on the pop side
    assign in_allowin = count != 2'd2;
    assign out_valid  = count != 2'd0;
    assign out_data   = entry[head];

    assign push = in_valid && in_allowin;
    assign pop  = out_valid && out_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= 1'b0;
            tail  <= 1'b0;
            count <= 2'd0;
        end else begin
            if (push) begin
                tail <= !tail;
            end
            if (pop) begin
                head <= !head;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    // entries written at the tail, read at the head
    always_ff @(posedge clk) begin
        if (push) begin
            entry[tail] <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- hw/agu_load_req.sv
`timescale 1ns/1ns
`default_nettype none

module agu_load_req (
    input  logic               clk,
    input  logic               reset,

    input  logic               in_valid,
    input  agu_pkg::agu_uop_t  in_uop,
    output logic               in_allowin,

    output logic               bus_req,
    output agu_pkg::dbus_req_t bus_cmd,
    input  logic               bus_grant,

    output logic               out_valid,
    output agu_pkg::agu_uop_t  out_uop,
    output agu_pkg::mem_exc_t  out_exc,
    input  logic               out_allowin
);

    agu_pkg::agu_uop_t uop;
    logic              valid;
    logic              misaligned;
    logic [2:0]        size;
    agu_pkg::mem_exc_t exc;

    always_comb begin
        case (uop.op)
            agu_pkg::OP_LB, agu_pkg::OP_LBU: begin
                size       = agu_pkg::SIZE_BYTE;
                misaligned = 1'b0;
            end
            agu_pkg::OP_LH, agu_pkg::OP_LHU: begin
                size       = agu_pkg::SIZE_HALF;
                misaligned = uop.addr[0];
            end
            default: begin
                size       = agu_pkg::SIZE_WORD;
                misaligned = uop.addr[1:0] != 2'b00;
            end
        endcase
    end

    always_comb begin
        exc = '0;
        if (misaligned) begin
            exc.ex       = 1'b1;
            exc.code     = agu_pkg::EXCCODE_ADEL;
            exc.badvaddr = uop.addr;
        end
    end

    // only ask when the response slot can take the load on grant;
    // that slot refills only from here, so the request stays up until grant
    assign bus_req       = valid && !exc.ex && out_allowin;
    assign bus_cmd.wr    = 1'b0;
    assign bus_cmd.strb  = 4'h0;
    assign bus_cmd.size  = size;
    assign bus_cmd.addr  = uop.addr;
    assign bus_cmd.wdata = '0;

    assign out_valid  = valid && (exc.ex || bus_grant);
    assign out_uop    = uop;
    assign out_exc    = exc;
    assign in_allowin = !valid || (out_valid && out_allowin);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (in_allowin) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_allowin && in_valid) begin
            uop <= in_uop;
        end
    end

endmodule

`default_nettype wire

//--- hw/agu_load_resp.sv
`timescale 1ns/1ns
`default_nettype none

module agu_load_resp (
    input  logic                     clk,
    input  logic                     reset,

    input  logic                     in_valid,
    input  agu_pkg::agu_uop_t        in_uop,
    input  agu_pkg::mem_exc_t        in_exc,
    output logic                     in_allowin,

    input  logic                     bus_data_ok,
    input  logic [agu_pkg::XLEN-1:0] bus_rdata,

    output logic                     done_valid,
    output agu_pkg::mem_done_t       done,
    input  logic                     done_allowin
);

    agu_pkg::agu_uop_t          uop;
    agu_pkg::mem_exc_t          exc;
    logic                       valid;
    logic                       held;
    logic [agu_pkg::XLEN-1:0]   held_result;
    logic [7:0]                 byte_sel;
    logic [15:0]                half_sel;
    logic [agu_pkg::XLEN-1:0]   result;
    logic                       go;

    // lane select by the low address bits
    assign byte_sel = bus_rdata[{uop.addr[1:0], 3'b000} +: 8];
    assign half_sel = uop.addr[1] ? bus_rdata[31:16] : bus_rdata[15:0];

    always_comb begin
        case (uop.op)
            agu_pkg::OP_LB:  result = {{24{byte_sel[7]}}, byte_sel};
            agu_pkg::OP_LBU: result = {24'b0, byte_sel};
            agu_pkg::OP_LH:  result = {{16{half_sel[15]}}, half_sel};
            agu_pkg::OP_LHU: result = {16'b0, half_sel};
            default:         result = bus_rdata;
        endcase
        if (exc.ex) begin
            result = '0;
        end
    end

    // an address error never went to the bus, so it finishes at once
    assign go         = exc.ex || bus_data_ok || held;
    assign done_valid = valid && go;

    assign done.rob    = uop.rob;
    assign done.pdest  = uop.pdest;
    assign done.result = held ? held_result : result;
    // exception was registered on entry and stays stable while held
    assign done.exc    = exc;

    assign in_allowin = !valid || (done_valid && done_allowin);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
            held  <= 1'b0;
        end else if (in_allowin) begin
            valid <= in_valid;
            held  <= 1'b0;
        end else if (done_valid && !held) begin
            // completion blocked while rdata is only valid for this cycle
            held <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (in_allowin && in_valid) begin
            uop <= in_uop;
            exc <= in_exc;
        end
        if (!in_allowin && done_valid && !held) begin
            held_result <= result;
        end
    end

endmodule

`default_nettype wire

//--- hw/agu_pkg.sv
`default_nettype none

package agu_pkg;

    localparam int XLEN   = 32;
    localparam int ROB_W  = 4;
    localparam int PREG_W = 6;
    localparam int EXC_W  = 5;

    // cp0 cause codes for address errors
    localparam logic [EXC_W-1:0] EXCCODE_ADEL = 5'd4;
    localparam logic [EXC_W-1:0] EXCCODE_ADES = 5'd5;

    // bus size code gives 1 << size bytes
    localparam logic [2:0] SIZE_BYTE = 3'd0;
    localparam logic [2:0] SIZE_HALF = 3'd1;
    localparam logic [2:0] SIZE_WORD = 3'd2;

    typedef enum logic [2:0] {
        OP_LB  = 3'd0,
        OP_LBU = 3'd1,
        OP_LH  = 3'd2,
        OP_LHU = 3'd3,
        OP_LW  = 3'd4,
        OP_SB  = 3'd5,
        OP_SH  = 3'd6,
        OP_SW  = 3'd7
    } mem_op_t;

    // operation as it leaves the issue queue
    typedef struct packed {
        mem_op_t            op;
        logic [XLEN-1:0]    base;
        logic [XLEN-1:0]    value;
        logic [15:0]        imm;
        logic [PREG_W-1:0]  pdest;
        logic [ROB_W-1:0]   rob;
    } mem_issue_t;

    typedef struct packed {
        logic               ex;
        logic [EXC_W-1:0]   code;
        logic [XLEN-1:0]    badvaddr;
    } mem_exc_t;

    typedef struct packed {
        logic [ROB_W-1:0]   rob;
        logic [PREG_W-1:0]  pdest;
        logic [XLEN-1:0]    result;
        mem_exc_t           exc;
    } mem_done_t;

    // head op with the effective address already formed
    typedef struct packed {
        mem_op_t            op;
        logic [XLEN-1:0]    addr;
        logic [XLEN-1:0]    value;
        logic [PREG_W-1:0]  pdest;
        logic [ROB_W-1:0]   rob;
    } agu_uop_t;

    typedef struct packed {
        logic               wr;
        logic [3:0]         strb;
        logic [2:0]         size;
        logic [XLEN-1:0]    addr;
        logic [XLEN-1:0]    wdata;
    } dbus_req_t;

endpackage

`default_nettype wire

//--- hw/agu_store_stage.sv
`timescale 1ns/1ns
`default_nettype none

module agu_store_stage (
    input  logic               clk,
    input  logic               reset,

    input  logic               in_valid,
    input  agu_pkg::agu_uop_t  in_uop,
    output logic               in_allowin,

    output logic               bus_req,
    output agu_pkg::dbus_req_t bus_cmd,
    input  logic               bus_grant,
    input  logic               bus_data_ok,

    output logic               done_valid,
    output agu_pkg::mem_done_t done,
    input  logic               done_allowin
);

    agu_pkg::agu_uop_t          uop;
    logic                       st_valid;
    logic                       st_wait;
    logic                       st_done;
    logic [1:0]                 ofs;
    logic                       misaligned;
    logic [3:0]                 strb;
    logic [2:0]                 size;
    logic [agu_pkg::XLEN-1:0]   wdata;
    agu_pkg::mem_exc_t          exc;

    assign ofs = uop.addr[1:0];

    // strobe, size and lane replication per store width
    always_comb begin
        strb       = 4'hf;
        size       = agu_pkg::SIZE_WORD;
        wdata      = uop.value;
        misaligned = ofs != 2'b00;
        case (uop.op)
            agu_pkg::OP_SB: begin
                strb       = 4'b0001 << ofs;
                size       = agu_pkg::SIZE_BYTE;
                wdata      = {4{uop.value[7:0]}};
                misaligned = 1'b0;
            end
            agu_pkg::OP_SH: begin
                strb       = ofs[1] ? 4'b1100 : 4'b0011;
                size       = agu_pkg::SIZE_HALF;
                wdata      = {2{uop.value[15:0]}};
                misaligned = ofs[0];
            end
            default: ;
        endcase
    end

    always_comb begin
        exc = '0;
        if (misaligned) begin
            exc.ex       = 1'b1;
            exc.code     = agu_pkg::EXCCODE_ADES;
            exc.badvaddr = uop.addr;
        end
    end

    // ask once, then wait for data_ok with the request dropped
    assign bus_req       = st_valid && !misaligned && !st_wait && !st_done;
    assign bus_cmd.wr    = 1'b1;
    assign bus_cmd.strb  = strb;
    assign bus_cmd.size  = size;
    assign bus_cmd.addr  = uop.addr;
    assign bus_cmd.wdata = wdata;

    assign done_valid  = st_valid && (misaligned || st_done);
    assign done.rob    = uop.rob;
    assign done.pdest  = uop.pdest;
    assign done.result = wdata;
    assign done.exc    = exc;

    assign in_allowin = !st_valid || (done_valid && done_allowin);

    always_ff @(posedge clk) begin
        if (reset) begin
            st_valid <= 1'b0;
            st_wait  <= 1'b0;
            st_done  <= 1'b0;
        end else if (in_allowin) begin
            st_valid <= in_valid;
            st_wait  <= 1'b0;
            st_done  <= 1'b0;
        end else begin
            if (bus_req && bus_grant) begin
                st_wait <= 1'b1;
            end
            if (st_wait && bus_data_ok) begin
                st_wait <= 1'b0;
                st_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_allowin && in_valid) begin
            uop <= in_uop;
        end
    end

endmodule

`default_nettype wire

//--- hw/agu_top.sv
`timescale 1ns/1ns
`default_nettype none

module agu_top (
    input  logic                     clk,
    input  logic                     reset,

    input  logic                     issue_valid,
    input  agu_pkg::mem_issue_t      issue,
    output logic                     issue_allowin,

    output logic                     dcache_req,
    output agu_pkg::dbus_req_t       dcache_cmd,
    input  logic                     dcache_addr_ok,
    input  logic                     dcache_data_ok,
    input  logic [agu_pkg::XLEN-1:0] dcache_rdata,

    output logic                     store_done_valid,
    output agu_pkg::mem_done_t       store_done,
    input  logic                     store_done_allowin,

    output logic                     load_done_valid,
    output agu_pkg::mem_done_t       load_done,
    input  logic                     load_done_allowin
);

    agu_pkg::mem_issue_t head;
    logic                head_valid;
    logic                head_allowin;
    logic                head_is_store;
    agu_pkg::agu_uop_t   head_uop;

    logic                st_in_allowin;
    logic                st_bus_req;
    agu_pkg::dbus_req_t  st_bus_cmd;
    logic                st_grant;
    logic                st_data_ok;

    logic                ld_in_allowin;
    logic                ld_bus_req;
    agu_pkg::dbus_req_t  ld_bus_cmd;
    logic                ld_grant;
    logic                ld_data_ok;

    logic                lr_valid;
    agu_pkg::agu_uop_t   lr_uop;
    agu_pkg::mem_exc_t   lr_exc;
    logic                lr_allowin;

    agu_issue_buffer #(
        .payload_t (agu_pkg::mem_issue_t)
    ) issue_buffer_inst (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (issue_valid),
        .in_data     (issue),
        .in_allowin  (issue_allowin),
        .out_valid   (head_valid),
        .out_data    (head),
        .out_allowin (head_allowin)
    );

    // effective address is base plus sign-extended imm16
    assign head_uop.op    = head.op;
    assign head_uop.addr  = head.base + {{16{head.imm[15]}}, head.imm};
    assign head_uop.value = head.value;
    assign head_uop.pdest = head.pdest;
    assign head_uop.rob   = head.rob;

    assign head_is_store = head.op inside {agu_pkg::OP_SB, agu_pkg::OP_SH, agu_pkg::OP_SW};
    assign head_allowin  = head_is_store ? st_in_allowin : ld_in_allowin;

    agu_store_stage store_stage_inst (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (head_valid && head_is_store),
        .in_uop       (head_uop),
        .in_allowin   (st_in_allowin),
        .bus_req      (st_bus_req),
        .bus_cmd      (st_bus_cmd),
        .bus_grant    (st_grant),
        .bus_data_ok  (st_data_ok),
        .done_valid   (store_done_valid),
        .done         (store_done),
        .done_allowin (store_done_allowin)
    );

    agu_load_req load_req_inst (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (head_valid && !head_is_store),
        .in_uop      (head_uop),
        .in_allowin  (ld_in_allowin),
        .bus_req     (ld_bus_req),
        .bus_cmd     (ld_bus_cmd),
        .bus_grant   (ld_grant),
        .out_valid   (lr_valid),
        .out_uop     (lr_uop),
        .out_exc     (lr_exc),
        .out_allowin (lr_allowin)
    );

    agu_load_resp load_resp_inst (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (lr_valid),
        .in_uop       (lr_uop),
        .in_exc       (lr_exc),
        .in_allowin   (lr_allowin),
        .bus_data_ok  (ld_data_ok),
        .bus_rdata    (dcache_rdata),
        .done_valid   (load_done_valid),
        .done         (load_done),
        .done_allowin (load_done_allowin)
    );

    dcache_port dcache_port_inst (
        .clk            (clk),
        .reset          (reset),
        .load_req       (ld_bus_req),
        .load_cmd       (ld_bus_cmd),
        .load_grant     (ld_grant),
        .load_data_ok   (ld_data_ok),
        .store_req      (st_bus_req),
        .store_cmd      (st_bus_cmd),
        .store_grant    (st_grant),
        .store_data_ok  (st_data_ok),
        .dcache_req     (dcache_req),
        .dcache_cmd     (dcache_cmd),
        .dcache_addr_ok (dcache_addr_ok),
        .dcache_data_ok (dcache_data_ok)
    );

endmodule

`default_nettype wire

//--- hw/dcache_port.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_port (
    input  logic               clk,
    input  logic               reset,

    input  logic               load_req,
    input  agu_pkg::dbus_req_t load_cmd,
    output logic               load_grant,
    output logic               load_data_ok,

    input  logic               store_req,
    input  agu_pkg::dbus_req_t store_cmd,
    output logic               store_grant,
    output logic               store_data_ok,

    output logic               dcache_req,
    output agu_pkg::dbus_req_t dcache_cmd,
    input  logic               dcache_addr_ok,
    input  logic               dcache_data_ok
);

    logic busy;
    logic pend;
    logic owner_load;
    logic sel_load;
    logic accept;

    // load wins, but a request already on the bus keeps its slot until accepted
    assign sel_load = pend ? owner_load : load_req;

    // one access at a time
    assign dcache_req = !busy && (sel_load ? load_req : store_req);
    assign dcache_cmd = sel_load ? load_cmd : store_cmd;
    assign accept     = dcache_req && dcache_addr_ok;

    assign load_grant  = accept && sel_load;
    assign store_grant = accept && !sel_load;

    // response goes back to whoever owns the outstanding access
    assign load_data_ok  = dcache_data_ok && busy && owner_load;
    assign store_data_ok = dcache_data_ok && busy && !owner_load;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            pend       <= 1'b0;
            owner_load <= 1'b0;
        end else begin
            if (dcache_req) begin
                owner_load <= sel_load;
            end
            pend <= dcache_req && !dcache_addr_ok;
            if (accept) begin
                busy <= 1'b1;
            end else if (dcache_data_ok) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/agu_assert.sv
`timescale 1ns/1ns
`default_nettype none

module agu_assert (
    input logic               clk,
    input logic               reset,
    input logic               dcache_req,
    input agu_pkg::dbus_req_t dcache_cmd,
    input logic               dcache_addr_ok,
    input logic               dcache_data_ok,
    input logic               store_done_valid,
    input agu_pkg::mem_done_t store_done,
    input logic               store_done_allowin,
    input logic               load_done_valid,
    input agu_pkg::mem_done_t load_done,
    input logic               load_done_allowin
);

    logic outstanding;

    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (dcache_req && dcache_addr_ok) begin
            outstanding <= 1'b1;
        end else if (dcache_data_ok) begin
            outstanding <= 1'b0;
        end
    end

    req_hold: assert property (@(posedge clk) disable iff (reset)
        dcache_req && !dcache_addr_ok |=> dcache_req && $stable(dcache_cmd))
        else $error("cache request dropped or changed before addr_ok");

    store_done_hold: assert property (@(posedge clk) disable iff (reset)
        store_done_valid && !store_done_allowin |=> store_done_valid && $stable(store_done))
        else $error("store completion dropped or changed before allowin");

    load_done_hold: assert property (@(posedge clk) disable iff (reset)
        load_done_valid && !load_done_allowin |=> load_done_valid && $stable(load_done))
        else $error("load completion dropped or changed before allowin");

    single_outstanding: assert property (@(posedge clk) disable iff (reset)
        outstanding |-> !(dcache_req && dcache_addr_ok))
        else $error("second cache access accepted while one is outstanding");

endmodule

bind agu_top agu_assert agu_assert_inst (.*);

`default_nettype wire

//--- sim/agu_checker.sv
`timescale 1ns/1ns
`default_nettype none

module agu_checker (
    input  logic               clk,
    input  logic               reset,
    input  logic               issue_allowin,
    input  logic               dcache_req,
    input  agu_pkg::dbus_req_t dcache_cmd,
    input  logic               dcache_addr_ok,
    input  logic               store_done_valid,
    input  agu_pkg::mem_done_t store_done,
    input  logic               store_done_allowin,
    input  logic               load_done_valid,
    input  agu_pkg::mem_done_t load_done,
    input  logic               load_done_allowin
);

    logic [3:0]         exp_rob [$];
    logic [5:0]         exp_pdest [$];
    logic               exp_store [$];
    logic [31:0]        exp_result [$];
    agu_pkg::mem_exc_t  exp_exc [$];
    logic               seen [$];
    // bus accesses in program order with one queue per side
    agu_pkg::dbus_req_t wr_q [$];
    agu_pkg::dbus_req_t rd_q [$];
    int                 done_count = 0;
    int                 mismatch_count = 0;
    int                 other_count = 0;

    task automatic expect_op(input logic [3:0] rob, input logic [5:0] pdest,
                             input logic is_store, input logic [31:0] result,
                             input agu_pkg::mem_exc_t exc, input logic has_bus,
                             input agu_pkg::dbus_req_t cmd);
        exp_rob.push_back(rob);
        exp_pdest.push_back(pdest);
        exp_store.push_back(is_store);
        exp_result.push_back(result);
        exp_exc.push_back(exc);
        seen.push_back(1'b0);
        if (has_bus && is_store) begin
            wr_q.push_back(cmd);
        end else if (has_bus) begin
            rd_q.push_back(cmd);
        end
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_bus(input agu_pkg::dbus_req_t cmd);
        agu_pkg::dbus_req_t e;
        if (cmd.wr ? wr_q.size() == 0 : rd_q.size() == 0) begin
            $display("unexpected cache %s request at address %h",
                     cmd.wr ? "write" : "read", cmd.addr);
            other_count++;
            return;
        end
        e = cmd.wr ? wr_q.pop_front() : rd_q.pop_front();
        compare("dcache_cmd.addr", cmd.addr, e.addr);
        compare("dcache_cmd.size", 32'(cmd.size), 32'(e.size));
        if (cmd.wr) begin
            compare("dcache_cmd.strb", 32'(cmd.strb), 32'(e.strb));
            compare("dcache_cmd.wdata", cmd.wdata, e.wdata);
        end
    endtask

    task automatic check_done(input agu_pkg::mem_done_t d, input logic is_store);
        int idx;
        idx = -1;
        foreach (exp_rob[i]) begin
            if (idx < 0 && !seen[i] && exp_rob[i] == d.rob) begin
                idx = i;
            end
        end
        if (idx < 0 || exp_store[idx] != is_store) begin
            $display("completion for ROB tag %h was not expected on this port", d.rob);
            other_count++;
            return;
        end
        seen[idx] = 1'b1;
        done_count++;
        compare("done.pdest", 32'(d.pdest), 32'(exp_pdest[idx]));
        compare("done.exc.ex", 32'(d.exc.ex), 32'(exp_exc[idx].ex));
        if (exp_exc[idx].ex) begin
            compare("done.exc.code", 32'(d.exc.code), 32'(exp_exc[idx].code));
            compare("done.exc.badvaddr", d.exc.badvaddr, exp_exc[idx].badvaddr);
        end else if (!is_store) begin
            compare("load_done.result", d.result, exp_result[idx]);
        end
    endtask

    task automatic check_idle();
        if (!issue_allowin) begin
            $display("issue_allowin is low after all operations completed");
            other_count++;
        end
        if (wr_q.size() + rd_q.size() != 0) begin
            $display("%0d expected cache requests never appeared", wr_q.size() + rd_q.size());
            other_count++;
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if (dcache_req && dcache_addr_ok) begin
                check_bus(dcache_cmd);
            end
            if (store_done_valid && store_done_allowin) begin
                check_done(store_done, 1'b1);
            end
            if (load_done_valid && load_done_allowin) begin
                check_done(load_done, 1'b0);
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/agu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module agu_clkgen #(
    parameter int PERIOD = 20
) (
    output logic clk
);

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

endmodule

module agu_tb;

    logic                     clk;
    logic                     reset;
    logic                     issue_valid;
    agu_pkg::mem_issue_t      issue;
    logic                     issue_allowin;
    logic                     dcache_req;
    agu_pkg::dbus_req_t       dcache_cmd;
    logic                     dcache_addr_ok;
    logic                     dcache_data_ok;
    logic [31:0]              dcache_rdata;
    logic                     store_done_valid;
    agu_pkg::mem_done_t       store_done;
    logic                     store_done_allowin;
    logic                     load_done_valid;
    agu_pkg::mem_done_t       load_done;
    logic                     load_done_allowin;

    agu_pkg::mem_issue_t      stim [$];
    int                       limit;
    int                       cycles;
    logic                     outstanding;
    logic [1:0]               wait_cnt;
    logic [31:0]              rd_addr;

    agu_clkgen #(.PERIOD(20)) clkgen_inst (.clk(clk));

    agu_top agu_top_inst (.*);

    agu_checker checker_inst (.*);

    // preload rule for the load region
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'ha5a5_0000;
    endfunction

    // builds one table row and its expected completion and bus access
    task automatic add_op(input agu_pkg::mem_op_t op, input logic [31:0] base,
                          input logic [15:0] imm);
        agu_pkg::mem_issue_t it;
        agu_pkg::mem_exc_t   exc;
        agu_pkg::dbus_req_t  cmd;
        logic [31:0]         addr;
        logic [31:0]         word;
        logic [7:0]          b;
        logic [15:0]         h;
        logic [31:0]         res;
        logic                is_store;
        it.op    = op;
        it.base  = base;
        it.imm   = imm;
        it.value = $urandom;
        it.rob   = 4'(stim.size() % 16);
        it.pdest = 6'(stim.size() + 1);
        addr     = base + {{16{imm[15]}}, imm};
        word     = mem_word(addr);
        b        = word[8 * addr[1:0] +: 8];
        h        = addr[1] ? word[31:16] : word[15:0];
        is_store = op inside {agu_pkg::OP_SB, agu_pkg::OP_SH, agu_pkg::OP_SW};
        exc      = '0;
        cmd      = '0;
        cmd.addr = addr;
        cmd.wr   = is_store;
        res      = word;
        cmd.size = agu_pkg::SIZE_WORD;
        cmd.strb = is_store ? 4'hf : 4'h0;
        cmd.wdata = is_store ? it.value : 32'h0;
        case (op)
            agu_pkg::OP_LB:  res = {{24{b[7]}}, b};
            agu_pkg::OP_LBU: res = {24'h0, b};
            agu_pkg::OP_LH:  res = {{16{h[15]}}, h};
            agu_pkg::OP_LHU: res = {16'h0, h};
            agu_pkg::OP_SB: begin
                cmd.strb  = 4'b0001 << addr[1:0];
                cmd.wdata = {4{it.value[7:0]}};
            end
            agu_pkg::OP_SH: begin
                cmd.strb  = addr[1] ? 4'b1100 : 4'b0011;
                cmd.wdata = {2{it.value[15:0]}};
            end
            default: ;
        endcase
        if (op inside {agu_pkg::OP_LB, agu_pkg::OP_LBU, agu_pkg::OP_SB}) begin
            cmd.size = agu_pkg::SIZE_BYTE;
        end else if (op inside {agu_pkg::OP_LH, agu_pkg::OP_LHU, agu_pkg::OP_SH}) begin
            cmd.size = agu_pkg::SIZE_HALF;
        end
        // halves need bit 0 clear and words both low bits
        if ((cmd.size == agu_pkg::SIZE_HALF && addr[0]) ||
            (cmd.size == agu_pkg::SIZE_WORD && addr[1:0] != 2'b00)) begin
            exc.ex       = 1'b1;
            exc.code     = is_store ? agu_pkg::EXCCODE_ADES : agu_pkg::EXCCODE_ADEL;
            exc.badvaddr = addr;
        end
        checker_inst.expect_op(it.rob, it.pdest, is_store, res, exc, !exc.ex, cmd);
        stim.push_back(it);
    endtask

    task automatic send(input agu_pkg::mem_issue_t it);
        issue_valid <= 1'b1;
        issue       <= it;
        @(negedge clk);
        while (!issue_allowin) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    initial begin
        void'($urandom(32'hf9e3));
        reset              = 1'b1;
        issue_valid        = 1'b0;
        issue              = '0;
        dcache_addr_ok     = 1'b0;
        dcache_data_ok     = 1'b0;
        dcache_rdata       = '0;
        store_done_allowin = 1'b0;
        load_done_allowin  = 1'b0;
        cycles             = 0;
        // loads stay below 0x1000 and stores above it
        for (int o = 0; o < 4; o++) begin
            add_op(agu_pkg::OP_LB, 32'h0000_0100, 16'(o));
            add_op(agu_pkg::OP_LBU, 32'h0000_0ff4, 16'(o - 4));
            add_op(agu_pkg::OP_SB, 32'h0000_2000, 16'(o));
        end
        add_op(agu_pkg::OP_LH, 32'h0000_0200, 16'h0000);
        add_op(agu_pkg::OP_LH, 32'h0000_0ff0, 16'h0002);
        add_op(agu_pkg::OP_LHU, 32'h0000_0208, 16'hfffa);
        add_op(agu_pkg::OP_LHU, 32'h0000_0ff8, 16'h0000);
        add_op(agu_pkg::OP_LW, 32'h0000_0300, 16'h0004);
        add_op(agu_pkg::OP_SH, 32'h0000_2100, 16'h0000);
        add_op(agu_pkg::OP_SH, 32'h0000_2100, 16'h0002);
        add_op(agu_pkg::OP_SW, 32'h0000_2200, 16'hfffc);
        add_op(agu_pkg::OP_LH, 32'h0000_0400, 16'h0001);
        add_op(agu_pkg::OP_LHU, 32'h0000_0400, 16'h0003);
        add_op(agu_pkg::OP_LW, 32'h0000_0404, 16'hfffe);
        add_op(agu_pkg::OP_SH, 32'h0000_3000, 16'h0001);
        add_op(agu_pkg::OP_SW, 32'h0000_3000, 16'h0003);
        limit = stim.size() * 20 + 200;

        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        foreach (stim[i]) begin
            send(stim[i]);
        end
        issue_valid <= 1'b0;

        while (checker_inst.done_count < stim.size()) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        checker_inst.check_idle();
        $display("%0d mismatches, %0d other errors", checker_inst.mismatch_count,
                 checker_inst.other_count);
        if (checker_inst.mismatch_count + checker_inst.other_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // cache model with one access at a time and data 1 to 4 cycles after accept
    always @(posedge clk) begin
        if (reset) begin
            outstanding    <= 1'b0;
            wait_cnt       <= 2'd0;
            rd_addr        <= '0;
            dcache_data_ok <= 1'b0;
            dcache_addr_ok <= 1'b0;
        end else begin
            dcache_data_ok <= 1'b0;
            if (outstanding) begin
                if (wait_cnt == 2'd0) begin
                    dcache_data_ok <= 1'b1;
                    dcache_rdata   <= mem_word(rd_addr);
                    outstanding    <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
            if (dcache_req && dcache_addr_ok) begin
                outstanding <= 1'b1;
                wait_cnt    <= 2'($urandom % 4);
                rd_addr     <= dcache_cmd.addr;
            end
            dcache_addr_ok <= ($urandom % 4) != 0;
        end
        store_done_allowin <= ($urandom % 3) != 0;
        load_done_allowin  <= ($urandom % 3) != 0;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, %0d of %0d operations completed",
                     cycles, checker_inst.done_count, stim.size());
            $display("Test FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire
